// ==== Makefile ====
# Verilator build for the video scaler testbench

VERILATOR ?= verilator
TOP       ?= tb_videoScaler
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out=$$(./$(SIM_BIN)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/scaler_patterns.txt ====
# name srcW-1 srcH-1 dstW-1 dstH-1 ratioX ratioY (Q2.8 hex) mode (0 bilinear, 1 nearest) gaps
# then one line of source pixels and one line of expected output pixels, raster order, hex
identity 2 2 2 2 100 100 0 0
10 20 30 40 50 60 70 80 90
10 20 30 40 50 60 70 80 90

upscaleHalf 1 1 3 3 080 080 0 0
10 31 50 90
10 20 31 31 30 48 60 60 50 70 90 90 50 70 90 90

nearest 2 2 3 3 0c0 0c0 1 0
11 12 13 21 22 23 31 32 33
11 12 13 13 21 22 23 23 31 32 33 33 31 32 33 33

downscale 3 3 2 1 200 200 0 0
05 0a 0f 14 19 1e 23 28 2d 32 37 3c 41 46 4b 50
05 0f 14 2d 37 3c

upscaleGaps 1 1 3 3 080 080 0 1
10 31 50 90
10 20 31 31 30 48 60 60 50 70 90 90 50 70 90 90

fracGaps 1 1 2 1 055 055 0 1
64 c8 32 fa
64 85 a6 53 7f ab

nearestGaps 2 2 3 3 0c0 0c0 1 1
11 12 13 21 22 23 31 32 33
11 12 13 13 21 22 23 23 31 32 33 33 31 32 33 33

// ==== dv/tb_videoScaler.sv ====
`timescale 1ns/1ps
`include "scaler_defs.svh"

module tb_videoScaler
	import scalerPkg::*;
();
	localparam int TIMEOUT = 5000; // Cycles allowed per test

	logic      clk;
	logic      rst;
	scaleCfg_t cfg;
	logic      inValid;
	pixel_t    inPixel;
	logic      inReady;
	logic      outRead;
	logic      outReady;
	pixel_t    outPixel;
	logic      outValid;
	int        errors;
	int        passed;
	int        failed;
	int        srcPix[$]; // Source frame, raster order
	int        expPix[$]; // Expected destination frame

	videoScaler i_dut (
		.clk(clk), .rst(rst), .i_cfg(cfg), .i_inValid(inValid), .i_inPixel(inPixel),
		.o_inReady(inReady), .i_outRead(outRead), .o_outReady(outReady),
		.o_outPixel(outPixel), .o_outValid(outValid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for three cycles, released on a falling edge
	task automatic applyReset();
		int n;
		@(negedge clk);
		rst = 1'b1;
		inValid = 1'b0;
		outRead = 1'b0;
		for (n = 0; n < 3; n++)
			@(negedge clk);
		rst = 1'b0;
	endtask

	task automatic runTest(input string name, input bit gaps);
		int     sent;
		int     issued;
		int     got;
		int     cycle;
		int     lat;
		int     n;
		int     startErrors;
		int     issueAt[$]; // Cycle of each issue still in flight
		pixel_t want;
		startErrors = errors;
		sent = 0;
		issued = 0;
		got = 0;
		cycle = 0;
		applyReset();
		assert (inReady && !outReady && !outValid) else begin
			$display("Test %s: handshake outputs not in their reset state", name);
			errors++;
		end
		while ((got < expPix.size() || issued < expPix.size()) && cycle < TIMEOUT) begin
			@(negedge clk);
			cycle++;
			// Outputs are stable here, half a cycle after the rising edge
			if (outValid) begin
				if (issueAt.size() == 0 || got >= expPix.size()) begin
					$display("Test %s: o_outValid without a matching issue", name);
					errors++;
				end else begin
					lat = cycle - issueAt.pop_front();
					want = pixel_t'(expPix[got]);
					assert (lat == `SCALER_LATENCY) else begin
						$display("ERROR %s latency expected %0d actual %0d", name,
							`SCALER_LATENCY, lat);
						errors++;
					end
					assert (outPixel == want) else begin
						$display("ERROR %s pixel %0d expected %h actual %h", name, got,
							want, outPixel);
						errors++;
					end
					got++;
				end
			end
			assert (!(outReady && sent < srcPix.size())) else begin
				$display("Test %s: o_outReady high before the last source pixel", name);
				errors++;
			end
			// New inputs, an accept or issue lands on the next rising edge
			inValid = (sent < srcPix.size()) && (!gaps || ($urandom % 4 != 0));
			if (inValid)
				inPixel = pixel_t'(srcPix[sent]);
			if (inValid && inReady)
				sent++;
			outRead = (issued < expPix.size()) && (!gaps || ($urandom % 3 != 0));
			if (outRead && outReady) begin
				issueAt.push_back(cycle);
				issued++;
			end
		end
		inValid = 1'b0;
		outRead = 1'b0;
		if (cycle >= TIMEOUT) begin
			$display("Test %s timed out with %0d of %0d pixels received", name, got,
				expPix.size());
			errors++;
		end
		// Pipeline drain, nothing more may come out
		for (n = 0; n < `SCALER_LATENCY + 2; n++) begin
			@(negedge clk);
			assert (!outValid) else begin
				$display("Test %s: extra o_outValid after the frame", name);
				errors++;
			end
		end
		assert (got == issued && inReady) else begin
			$display("Test %s: output count differs from issues or store did not reopen",
				name);
			errors++;
		end
		if (errors == startErrors) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s", name);
			failed++;
		end
	endtask

	task automatic runAllTests(input int fd);
		string name;
		string skip;
		int    srcW, srcH, dstW, dstH;
		int    rx, ry, mode, gaps;
		int    v;
		int    n;
		void'($fgets(skip, fd)); // Column key lines
		void'($fgets(skip, fd));
		while ($fscanf(fd, "%s %d %d %d %d %h %h %d %d", name, srcW, srcH, dstW, dstH,
				rx, ry, mode, gaps) == 9) begin
			cfg.srcW = dim_t'(srcW);
			cfg.srcH = dim_t'(srcH);
			cfg.dstW = dim_t'(dstW);
			cfg.dstH = dim_t'(dstH);
			cfg.ratioX = ratio_t'(rx);
			cfg.ratioY = ratio_t'(ry);
			cfg.mode = mode[0];
			srcPix.delete();
			expPix.delete();
			for (n = 0; n < (srcW + 1) * (srcH + 1); n++) begin
				void'($fscanf(fd, "%h", v));
				srcPix.push_back(v);
			end
			for (n = 0; n < (dstW + 1) * (dstH + 1); n++) begin
				void'($fscanf(fd, "%h", v));
				expPix.push_back(v);
			end
			runTest(name, gaps != 0);
		end
	endtask

	initial begin
		int fd;
		rst = 1'b1;
		cfg = '0;
		inValid = 1'b0;
		inPixel = '0;
		outRead = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		void'($urandom(32'hfc42));
		fd = $fopen("dv/scaler_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/scaler_patterns.txt");
			errors++;
		end else begin
			runAllTests(fd);
			$fclose(fd);
		end
		$display("Summary: %0d passed, %0d failing, %0d errors", passed, failed, errors);
		if (errors == 0 && failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/scalerPkg.sv
verilog/frameStore.sv
verilog/pixelStepper.sv
verilog/blendCoeff.sv
verilog/blendOutput.sv
verilog/videoScaler.sv
dv/tb_videoScaler.sv

// ==== verilog/blendCoeff.sv ====
`timescale 1ns/1ps
`include "scaler_defs.svh"

module blendCoeff
	import scalerPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  pixTap_t    i_tap,
	input  logic       i_mode,
	output coeffQuad_t o_coeff
);
	localparam int PROD_W = 2 * (`SCALER_FRAC_W + 1); // Q1.8 times Q1.8
	localparam coeff_t ONE = coeff_t'(1 << `SCALER_FRAC_W);

	coeff_t xF;
	coeff_t yF;
	coeff_t invX; // 1 - xFrac
	coeff_t invY;
	logic   xHi; // Fraction at or past one half
	logic   yHi;
	int     weightSum; // Registered weights added up

	// Back to Q1.8 with rounding
	function automatic coeff_t roundQ8(input logic [PROD_W-1:0] prod);
		logic [PROD_W-1:0] rounded;
		rounded = prod + PROD_W'(127);
		return rounded[2*`SCALER_FRAC_W:`SCALER_FRAC_W];
	endfunction

	assign xF = {1'b0, i_tap.xFrac};
	assign yF = {1'b0, i_tap.yFrac};
	assign invX = ONE - xF;
	assign invY = ONE - yF;
	assign xHi = i_tap.xFrac[`SCALER_FRAC_W-1];
	assign yHi = i_tap.yFrac[`SCALER_FRAC_W-1];

	always_ff @(posedge clk) begin
		if (!i_mode) begin // Bilinear weights
			o_coeff.c00 <= roundQ8(PROD_W'(invX) * PROD_W'(invY));
			o_coeff.c01 <= roundQ8(PROD_W'(xF) * PROD_W'(invY));
			o_coeff.c10 <= roundQ8(PROD_W'(invX) * PROD_W'(yF));
			o_coeff.c11 <= roundQ8(PROD_W'(xF) * PROD_W'(yF));
		end else begin
			// Nearest picks one quadrant by the fraction MSBs
			o_coeff.c00 <= (!xHi && !yHi) ? ONE : '0;
			o_coeff.c01 <= (xHi && !yHi) ? ONE : '0;
			o_coeff.c10 <= (!xHi && yHi) ? ONE : '0;
			o_coeff.c11 <= (xHi && yHi) ? ONE : '0;
		end
	end

	assign weightSum = int'(o_coeff.c00) + int'(o_coeff.c01) + int'(o_coeff.c10) +
		int'(o_coeff.c11);

	// Four rounded bilinear weights stay within the rounding error of unity
	assert property (@(posedge clk) disable iff (rst)
		!$past(i_mode) |-> (weightSum >= int'(ONE) - 2 && weightSum <= int'(ONE) + 1));

endmodule

// ==== verilog/blendOutput.sv ====
`timescale 1ns/1ps
`include "scaler_defs.svh"

module blendOutput
	import scalerPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  pixQuad_t   i_quad,
	input  coeffQuad_t i_coeff,
	input  logic       i_issue,
	output pixel_t     o_outPixel,
	output logic       o_outValid
);
	localparam int PROD_W = `SCALER_PIX_W + `SCALER_FRAC_W + 1; // 8 bit pixel times Q1.8
	localparam int SUM_W = PROD_W + 2; // Four terms

	logic [PROD_W-1:0]          prod00;
	logic [PROD_W-1:0]          prod01;
	logic [PROD_W-1:0]          prod10;
	logic [PROD_W-1:0]          prod11;
	logic [SUM_W-1:0]           sum;
	logic [`SCALER_LATENCY-1:0] validPipe; // Issue flag follows its pixel

	// Stage at +2
	always_ff @(posedge clk) begin
		prod00 <= PROD_W'(i_quad.p00) * PROD_W'(i_coeff.c00);
		prod01 <= PROD_W'(i_quad.p01) * PROD_W'(i_coeff.c01);
		prod10 <= PROD_W'(i_quad.p10) * PROD_W'(i_coeff.c10);
		prod11 <= PROD_W'(i_quad.p11) * PROD_W'(i_coeff.c11);
	end

	assign sum = SUM_W'(prod00) + SUM_W'(prod01) + SUM_W'(prod10) + SUM_W'(prod11);

	// Stage at +3, drop the fraction and keep the low byte
	always_ff @(posedge clk) begin
		o_outPixel <= sum[`SCALER_FRAC_W +: `SCALER_PIX_W];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			validPipe <= '0;
		else
			validPipe <= {validPipe[`SCALER_LATENCY-2:0], i_issue};
	end

	assign o_outValid = validPipe[`SCALER_LATENCY-1];

endmodule

// ==== verilog/frameStore.sv ====
`timescale 1ns/1ps
`include "scaler_defs.svh"

module frameStore
	import scalerPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_inValid,
	input  pixel_t    i_inPixel,
	output logic      o_inReady,
	input  scaleCfg_t i_cfg,
	input  pixTap_t   i_tap,
	input  logic      i_frameEnd,
	output logic      o_frameLoaded,
	output pixQuad_t  o_quad
);
	pixel_t mem [1 << `SCALER_ADDR_W]; // Whole source frame, row major
	dim_t   wrCol;
	dim_t   wrRow;
	logic   loaded;
	logic   wrEn;

	// Row in the high bits and column in the low bits
	function automatic logic [`SCALER_ADDR_W-1:0] pixAddr(input dim_t row, input dim_t col);
		return {row, col};
	endfunction

	assign wrEn = i_inValid && o_inReady;
	assign o_inReady = !loaded; // Closed from the last pixel until the frame is output
	assign o_frameLoaded = loaded;

	// Raster write position and load flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrCol <= '0;
			wrRow <= '0;
			loaded <= 1'b0;
		end else if (wrEn) begin
			if (wrCol == i_cfg.srcW) begin // End of a source line
				wrCol <= '0;
				if (wrRow == i_cfg.srcH) begin
					wrRow <= '0;
					loaded <= 1'b1; // Last pixel of the frame
				end else begin
					wrRow <= wrRow + 1'b1;
				end
			end else begin
				wrCol <= wrCol + 1'b1;
			end
		end else if (i_frameEnd) begin
			loaded <= 1'b0; // Reopen for the next frame
		end
	end

	always_ff @(posedge clk) begin
		if (wrEn)
			mem[pixAddr(wrRow, wrCol)] <= i_inPixel;
	end

	// Four neighbour reads per cycle that are valid one cycle after the issue
	always_ff @(posedge clk) begin
		o_quad.p00 <= mem[pixAddr(i_tap.y0, i_tap.x0)]; // Top left
		o_quad.p01 <= mem[pixAddr(i_tap.y0, i_tap.x1)];
		o_quad.p10 <= mem[pixAddr(i_tap.y1, i_tap.x0)];
		o_quad.p11 <= mem[pixAddr(i_tap.y1, i_tap.x1)]; // Bottom right
	end

	// Frame end only arrives while a loaded frame is being scaled
	assert property (@(posedge clk) disable iff (rst) i_frameEnd |-> o_frameLoaded);

endmodule

// ==== verilog/pixelStepper.sv ====
`timescale 1ns/1ps
`include "scaler_defs.svh"

module pixelStepper
	import scalerPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  scaleCfg_t i_cfg,
	input  logic      i_frameLoaded,
	input  logic      i_outRead,
	output logic      o_outReady,
	output pixTap_t   o_tap,
	output logic      o_issue,
	output logic      o_frameEnd
);
	// Largest coordinate is 31 steps of just under 4.0
	localparam int ACC_W = `SCALER_DIM_W + `SCALER_RATIO_INT_W + `SCALER_FRAC_W;
	localparam int INT_W = ACC_W - `SCALER_FRAC_W;

	dim_t             dstCol;
	dim_t             dstLine;
	logic [ACC_W-1:0] accX; // Source x in Q.8 as dstCol * ratioX
	logic [ACC_W-1:0] accY; // Source y in Q.8 as dstLine * ratioY
	logic             done;
	logic             lastCol;
	logic             lastLine;
	logic [INT_W-1:0] intX;
	logic [INT_W-1:0] intY;
	dim_t             x0;
	dim_t             y0;

	assign o_outReady = i_frameLoaded && !done;
	assign o_issue = i_outRead && o_outReady;
	assign lastCol = dstCol == i_cfg.dstW;
	assign lastLine = dstLine == i_cfg.dstH;

	// Integer part clamped to the source edge
	assign intX = accX[ACC_W-1:`SCALER_FRAC_W];
	assign intY = accY[ACC_W-1:`SCALER_FRAC_W];
	assign x0 = (intX > INT_W'(i_cfg.srcW)) ? i_cfg.srcW : intX[`SCALER_DIM_W-1:0];
	assign y0 = (intY > INT_W'(i_cfg.srcH)) ? i_cfg.srcH : intY[`SCALER_DIM_W-1:0];

	always_comb begin
		o_tap.x0 = x0;
		o_tap.x1 = (x0 == i_cfg.srcW) ? x0 : x0 + 1'b1; // Repeat the edge pixel
		o_tap.y0 = y0;
		o_tap.y1 = (y0 == i_cfg.srcH) ? y0 : y0 + 1'b1;
		o_tap.xFrac = accX[`SCALER_FRAC_W-1:0];
		o_tap.yFrac = accY[`SCALER_FRAC_W-1:0];
	end

	// Raster walk over the destination frame
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dstCol <= '0;
			dstLine <= '0;
			accX <= '0;
			accY <= '0;
			done <= 1'b0;
			o_frameEnd <= 1'b0;
		end else begin
			o_frameEnd <= o_issue && lastCol && lastLine; // One cycle after the final issue
			if (!i_frameLoaded)
				done <= 1'b0; // Store has reopened
			if (o_issue) begin
				if (lastCol) begin
					dstCol <= '0;
					accX <= '0;
					if (lastLine) begin
						dstLine <= '0;
						accY <= '0;
						done <= 1'b1;
					end else begin
						dstLine <= dstLine + 1'b1;
						accY <= accY + ACC_W'(i_cfg.ratioY);
					end
				end else begin
					dstCol <= dstCol + 1'b1;
					accX <= accX + ACC_W'(i_cfg.ratioX); // Step instead of multiply
				end
			end
		end
	end

	// Stepped accumulators equal the destination position times the ratio
	assert property (@(posedge clk) disable iff (rst)
		o_issue |-> (accX == ACC_W'(dstCol) * ACC_W'(i_cfg.ratioX) &&
			accY == ACC_W'(dstLine) * ACC_W'(i_cfg.ratioY)));

endmodule

// ==== verilog/scalerPkg.sv ====
`include "scaler_defs.svh"

package scalerPkg;

	typedef logic [`SCALER_PIX_W-1:0] pixel_t;
	typedef logic [`SCALER_DIM_W-1:0] dim_t; // Size minus 1
	typedef logic [`SCALER_RATIO_INT_W+`SCALER_FRAC_W-1:0] ratio_t; // Q2.8 step
	typedef logic [`SCALER_FRAC_W:0] coeff_t; // Q1.8, 256 is unity

	typedef struct packed {
		dim_t   srcW;
		dim_t   srcH;
		dim_t   dstW;
		dim_t   dstH;
		ratio_t ratioX;
		ratio_t ratioY;
		logic   mode; // 0 bilinear, 1 nearest
	} scaleCfg_t;

	// Neighbour coordinates and blend position for one destination pixel
	typedef struct packed {
		dim_t                     x0;
		dim_t                     x1;
		dim_t                     y0;
		dim_t                     y1;
		logic [`SCALER_FRAC_W-1:0] xFrac;
		logic [`SCALER_FRAC_W-1:0] yFrac;
	} pixTap_t;

	typedef struct packed {pixel_t p00; pixel_t p01; pixel_t p10; pixel_t p11;} pixQuad_t;
	typedef struct packed {coeff_t c00; coeff_t c01; coeff_t c10; coeff_t c11;} coeffQuad_t;

endpackage

// ==== verilog/scaler_defs.svh ====
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

// Pixel sample width
`define SCALER_PIX_W 8

// Resolution fields hold the size minus 1, up to 32 pixels
`define SCALER_DIM_W 5

// Fraction bits shared by ratios, coordinates and blend weights
`define SCALER_FRAC_W 8

// Integer bits of a ratio, so steps below 4.0
`define SCALER_RATIO_INT_W 2

// Frame store holds 32 lines of 32 pixels
`define SCALER_ADDR_W 10

// Issue to o_outValid, in clock cycles
`define SCALER_LATENCY 3

`endif

// ==== verilog/videoScaler.sv ====
`timescale 1ns/1ps

module videoScaler
	import scalerPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  scaleCfg_t i_cfg, // Held stable for the whole frame
	input  logic      i_inValid,
	input  pixel_t    i_inPixel,
	output logic      o_inReady,
	input  logic      i_outRead,
	output logic      o_outReady,
	output pixel_t    o_outPixel,
	output logic      o_outValid
);
	logic       frameLoaded;
	logic       frameEnd;
	logic       issueValid;
	pixTap_t    issueTap;
	pixQuad_t   quad;
	coeffQuad_t coeff;

	// Source frame capture and neighbour fetch
	frameStore store (
		.clk(clk), .rst(rst),
		.i_inValid(i_inValid), .i_inPixel(i_inPixel), .o_inReady(o_inReady),
		.i_cfg(i_cfg), .i_tap(issueTap), .i_frameEnd(frameEnd),
		.o_frameLoaded(frameLoaded), .o_quad(quad)
	);

	pixelStepper stepper (
		.clk(clk), .rst(rst), .i_cfg(i_cfg), .i_frameLoaded(frameLoaded),
		.i_outRead(i_outRead), .o_outReady(o_outReady), .o_tap(issueTap),
		.o_issue(issueValid), .o_frameEnd(frameEnd)
	);

	blendCoeff coeffGen (
		.clk(clk), .rst(rst), .i_tap(issueTap), .i_mode(i_cfg.mode), .o_coeff(coeff)
	);

	// Weighted sum of the four neighbours
	blendOutput blend (
		.clk(clk), .rst(rst), .i_quad(quad), .i_coeff(coeff), .i_issue(issueValid),
		.o_outPixel(o_outPixel), .o_outValid(o_outValid)
	);

endmodule
